// File: design/ooo_pkg.sv
package ooo_pkg;

    // ========================================================================
    // default sizes, overridden through the top level parameters
    // ========================================================================
    localparam int XLEN_DEF      = 32;
    localparam int PHYS_REGS_DEF = 64;
    localparam int RS_DEPTH_DEF  = 8;

    // ========================================================================
    // instruction fields
    // ========================================================================
    // alu operation code
    typedef logic [2:0]  alu_op_t;
    // raw immediate, sign-extended to XLEN in execute
    typedef logic [11:0] imm_t;

    // register-register ops
    localparam alu_op_t OP_ADD  = 3'd0;
    localparam alu_op_t OP_SUB  = 3'd1;
    localparam alu_op_t OP_AND  = 3'd2;
    localparam alu_op_t OP_OR   = 3'd3;
    localparam alu_op_t OP_XOR  = 3'd4;
    // shifts take the low 5 bits of operand 2
    localparam alu_op_t OP_SLL  = 3'd5;
    localparam alu_op_t OP_SRL  = 3'd6;
    // immediate replaces source 2
    localparam alu_op_t OP_ADDI = 3'd7;

endpackage

// File: design/dispatch_decode.sv
`timescale 1ns/1ps

module dispatch_decode import ooo_pkg::*; #(
    parameter  int PHYS_REGS = PHYS_REGS_DEF,
    localparam int TAG_W     = $clog2(PHYS_REGS)
) (
    input  logic             clock,
    input  logic             rst_n_i,
    // renamed instruction in
    input  logic             disp_valid_i,
    input  alu_op_t          disp_op_i,
    input  logic [TAG_W-1:0] disp_src1_i,
    input  logic [TAG_W-1:0] disp_src2_i,
    input  logic [TAG_W-1:0] disp_dest_i,
    input  imm_t             disp_imm_i,
    // completion broadcast
    input  logic             cdb_valid_i,
    input  logic [TAG_W-1:0] cdb_tag_i,
    // decoded entry toward the station
    output logic             dec_valid_o,
    output alu_op_t          dec_op_o,
    output logic [TAG_W-1:0] dec_src1_o,
    output logic             dec_src1_rdy_o,
    output logic [TAG_W-1:0] dec_src2_o,
    output logic             dec_src2_rdy_o,
    output logic [TAG_W-1:0] dec_dest_o,
    output imm_t             dec_imm_o
);

    // one busy bit per physical register
    logic [PHYS_REGS-1:0] busy_q;
    logic                 cdb_hit1;
    logic                 cdb_hit2;

    // ========================================================================
    // busy table
    // ========================================================================
    always_ff @(posedge clock) begin : busy_table
        if (!rst_n_i) begin
            busy_q <= '0;
        end else begin
            // producer done
            if (cdb_valid_i) begin
                busy_q[cdb_tag_i] <= 1'b0;
            end
            // new producer, set after the clear
            if (disp_valid_i) begin
                busy_q[disp_dest_i] <= 1'b1;
            end
        end
    end

    // ========================================================================
    // source readiness
    // ========================================================================
    // same-cycle cdb bypass, otherwise the wake-up would be missed
    assign cdb_hit1 = cdb_valid_i && (cdb_tag_i == disp_src1_i);
    assign cdb_hit2 = cdb_valid_i && (cdb_tag_i == disp_src2_i);

    assign dec_valid_o    = disp_valid_i;
    assign dec_op_o       = disp_op_i;
    assign dec_src1_o     = disp_src1_i;
    assign dec_src2_o     = disp_src2_i;
    assign dec_dest_o     = disp_dest_i;
    assign dec_imm_o      = disp_imm_i;
    assign dec_src1_rdy_o = !busy_q[disp_src1_i] || cdb_hit1;
    // addi has no second register source
    assign dec_src2_rdy_o = (disp_op_i == OP_ADDI) || !busy_q[disp_src2_i] || cdb_hit2;

    // a destination is only reused once its previous producer completed
    dest_not_busy: assert property (@(posedge clock) disable iff (!rst_n_i)
        disp_valid_i |-> !busy_q[disp_dest_i]
                         || (cdb_valid_i && (cdb_tag_i == disp_dest_i)))
        else $error("dispatch names busy destination tag %0d", disp_dest_i);

endmodule

// File: design/rs_station.sv
`timescale 1ns/1ps

module rs_station import ooo_pkg::*; #(
    parameter  int PHYS_REGS = PHYS_REGS_DEF,
    parameter  int RS_DEPTH  = RS_DEPTH_DEF,
    localparam int TAG_W     = $clog2(PHYS_REGS),
    localparam int IDX_W     = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1
) (
    input  logic             clock,
    input  logic             rst_n_i,
    // decoded entry
    input  logic             dec_valid_i,
    input  alu_op_t          dec_op_i,
    input  logic [TAG_W-1:0] dec_src1_i,
    input  logic             dec_src1_rdy_i,
    input  logic [TAG_W-1:0] dec_src2_i,
    input  logic             dec_src2_rdy_i,
    input  logic [TAG_W-1:0] dec_dest_i,
    input  imm_t             dec_imm_i,
    // wake-up
    input  logic             cdb_valid_i,
    input  logic [TAG_W-1:0] cdb_tag_i,
    // issue toward execute
    output logic             iss_valid_o,
    output alu_op_t          iss_op_o,
    output logic [TAG_W-1:0] iss_src1_o,
    output logic [TAG_W-1:0] iss_src2_o,
    output logic [TAG_W-1:0] iss_dest_o,
    output imm_t             iss_imm_o,
    output logic             rs_full_o
);

    // entry state, folded into arrays
    logic [RS_DEPTH-1:0] ent_valid_q;
    logic [RS_DEPTH-1:0] ent_rdy1_q;
    logic [RS_DEPTH-1:0] ent_rdy2_q;
    alu_op_t             ent_op_q   [RS_DEPTH];
    logic [TAG_W-1:0]    ent_src1_q [RS_DEPTH];
    logic [TAG_W-1:0]    ent_src2_q [RS_DEPTH];
    logic [TAG_W-1:0]    ent_dest_q [RS_DEPTH];
    imm_t                ent_imm_q  [RS_DEPTH];

    logic                alloc_found;
    logic [IDX_W-1:0]    alloc_idx;
    logic                iss_found;
    logic [IDX_W-1:0]    iss_idx;

    // ========================================================================
    // slot selection
    // ========================================================================
    always_comb begin : select_slots
        alloc_found = 1'b0;
        alloc_idx   = '0;
        iss_found   = 1'b0;
        iss_idx     = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            // lowest empty slot takes the new entry
            if (!ent_valid_q[i] && !alloc_found) begin
                alloc_found = 1'b1;
                alloc_idx   = IDX_W'(i);
            end
            // lowest entry with both operands ready goes out
            if (ent_valid_q[i] && ent_rdy1_q[i] && ent_rdy2_q[i] && !iss_found) begin
                iss_found = 1'b1;
                iss_idx   = IDX_W'(i);
            end
        end
    end

    assign rs_full_o = !alloc_found;

    // ========================================================================
    // occupancy
    // ========================================================================
    // issued slot is never the allocated one, it is still valid here
    always_ff @(posedge clock) begin : occupancy
        if (!rst_n_i) begin
            ent_valid_q <= '0;
        end else begin
            if (iss_found) begin
                ent_valid_q[iss_idx] <= 1'b0;
            end
            if (dec_valid_i && alloc_found) begin
                ent_valid_q[alloc_idx] <= 1'b1;
            end
        end
    end

    // ========================================================================
    // payload and wake-up
    // ========================================================================
    always_ff @(posedge clock) begin : entry_fill
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (dec_valid_i && alloc_found && (alloc_idx == IDX_W'(i))) begin
                ent_op_q[i]   <= dec_op_i;
                ent_src1_q[i] <= dec_src1_i;
                ent_src2_q[i] <= dec_src2_i;
                ent_dest_q[i] <= dec_dest_i;
                ent_imm_q[i]  <= dec_imm_i;
                ent_rdy1_q[i] <= dec_src1_rdy_i;
                ent_rdy2_q[i] <= dec_src2_rdy_i;
            end else if (cdb_valid_i) begin
                // tag match on the bus
                if (ent_src1_q[i] == cdb_tag_i) begin
                    ent_rdy1_q[i] <= 1'b1;
                end
                if (ent_src2_q[i] == cdb_tag_i) begin
                    ent_rdy2_q[i] <= 1'b1;
                end
            end
        end
    end

    // issue outputs
    assign iss_valid_o = iss_found;
    assign iss_op_o    = ent_op_q[iss_idx];
    assign iss_src1_o  = ent_src1_q[iss_idx];
    assign iss_src2_o  = ent_src2_q[iss_idx];
    assign iss_dest_o  = ent_dest_q[iss_idx];
    assign iss_imm_o   = ent_imm_q[iss_idx];

    // producer must honour rs_full_o
    no_disp_when_full: assert property (@(posedge clock) disable iff (!rst_n_i)
        dec_valid_i |-> alloc_found)
        else $error("dispatch into a full reservation station");

endmodule

// File: design/alu_execute.sv
`timescale 1ns/1ps

module alu_execute import ooo_pkg::*; #(
    parameter  int XLEN      = XLEN_DEF,
    parameter  int PHYS_REGS = PHYS_REGS_DEF,
    localparam int TAG_W     = $clog2(PHYS_REGS)
) (
    input  logic             clock,
    input  logic             rst_n_i,
    // issued entry
    input  logic             iss_valid_i,
    input  alu_op_t          iss_op_i,
    input  logic [TAG_W-1:0] iss_src1_i,
    input  logic [TAG_W-1:0] iss_src2_i,
    input  logic [TAG_W-1:0] iss_dest_i,
    input  imm_t             iss_imm_i,
    // operand read port
    input  logic [XLEN-1:0]  rd_data1_i,
    input  logic [XLEN-1:0]  rd_data2_i,
    output logic [TAG_W-1:0] rd_tag1_o,
    output logic [TAG_W-1:0] rd_tag2_o,
    // result toward writeback
    output logic             res_valid_o,
    output logic [TAG_W-1:0] res_tag_o,
    output logic [XLEN-1:0]  res_data_o
);

    // issue register
    logic             ex_valid_q;
    alu_op_t          ex_op_q;
    logic [TAG_W-1:0] ex_src1_q;
    logic [TAG_W-1:0] ex_src2_q;
    logic [TAG_W-1:0] ex_dest_q;
    imm_t             ex_imm_q;

    logic [XLEN-1:0]  imm_ext;
    logic [XLEN-1:0]  alu_result;

    always_ff @(posedge clock) begin : issue_valid
        if (!rst_n_i) begin
            ex_valid_q <= 1'b0;
        end else begin
            ex_valid_q <= iss_valid_i;
        end
    end

    always_ff @(posedge clock) begin : issue_payload
        ex_op_q   <= iss_op_i;
        ex_src1_q <= iss_src1_i;
        ex_src2_q <= iss_src2_i;
        ex_dest_q <= iss_dest_i;
        ex_imm_q  <= iss_imm_i;
    end

    // ========================================================================
    // operand read and alu
    // ========================================================================
    assign rd_tag1_o = ex_src1_q;
    assign rd_tag2_o = ex_src2_q;
    // sign-extend the 12-bit immediate
    assign imm_ext   = {{(XLEN-$bits(imm_t)){ex_imm_q[$bits(imm_t)-1]}}, ex_imm_q};

    always_comb begin : alu
        case (ex_op_q)
            OP_ADD:  alu_result = rd_data1_i + rd_data2_i;
            OP_SUB:  alu_result = rd_data1_i - rd_data2_i;
            OP_AND:  alu_result = rd_data1_i & rd_data2_i;
            OP_OR:   alu_result = rd_data1_i | rd_data2_i;
            OP_XOR:  alu_result = rd_data1_i ^ rd_data2_i;
            // shift amount from low 5 bits only
            OP_SLL:  alu_result = rd_data1_i << rd_data2_i[4:0];
            OP_SRL:  alu_result = rd_data1_i >> rd_data2_i[4:0];
            OP_ADDI: alu_result = rd_data1_i + imm_ext;
            default: alu_result = '0;
        endcase
    end

    assign res_valid_o = ex_valid_q;
    assign res_tag_o   = ex_dest_q;
    assign res_data_o  = alu_result;

endmodule

// File: design/cdb_result.sv
`timescale 1ns/1ps

module cdb_result import ooo_pkg::*; #(
    parameter  int XLEN      = XLEN_DEF,
    parameter  int PHYS_REGS = PHYS_REGS_DEF,
    localparam int TAG_W     = $clog2(PHYS_REGS)
) (
    input  logic             clock,
    input  logic             rst_n_i,
    // alu result
    input  logic             res_valid_i,
    input  logic [TAG_W-1:0] res_tag_i,
    input  logic [XLEN-1:0]  res_data_i,
    // initial register load
    input  logic             init_we_i,
    input  logic [TAG_W-1:0] init_tag_i,
    input  logic [XLEN-1:0]  init_data_i,
    // operand reads from execute
    input  logic [TAG_W-1:0] rd_tag1_i,
    input  logic [TAG_W-1:0] rd_tag2_i,
    output logic [XLEN-1:0]  rd_data1_o,
    output logic [XLEN-1:0]  rd_data2_o,
    // common data bus
    output logic             cdb_valid_o,
    output logic [TAG_W-1:0] cdb_tag_o,
    output logic [XLEN-1:0]  cdb_data_o
);

    // physical register file
    logic [XLEN-1:0] prf_q [PHYS_REGS];

    // ========================================================================
    // writeback
    // ========================================================================
    always_ff @(posedge clock) begin : prf_write
        if (init_we_i) begin
            prf_q[init_tag_i] <= init_data_i;
        end
        if (res_valid_i) begin
            prf_q[res_tag_i] <= res_data_i;
        end
    end

    // broadcast lines up with the register file write
    always_ff @(posedge clock) begin : cdb_valid_reg
        if (!rst_n_i) begin
            cdb_valid_o <= 1'b0;
        end else begin
            cdb_valid_o <= res_valid_i;
        end
    end

    always_ff @(posedge clock) begin : cdb_payload_reg
        cdb_tag_o  <= res_tag_i;
        cdb_data_o <= res_data_i;
    end

    // ========================================================================
    // read ports
    // ========================================================================
    // write-through on the load port
    // result writes need no path here, consumers wake a cycle after the cdb
    assign rd_data1_o = (init_we_i && (init_tag_i == rd_tag1_i)) ? init_data_i
                                                                 : prf_q[rd_tag1_i];
    assign rd_data2_o = (init_we_i && (init_tag_i == rd_tag2_i)) ? init_data_i
                                                                 : prf_q[rd_tag2_i];

endmodule

// File: design/ooo_core.sv
`timescale 1ns/1ps

module ooo_core import ooo_pkg::*; #(
    parameter  int XLEN      = XLEN_DEF,
    parameter  int PHYS_REGS = PHYS_REGS_DEF,
    parameter  int RS_DEPTH  = RS_DEPTH_DEF,
    localparam int TAG_W     = $clog2(PHYS_REGS)
) (
    input  logic             clock,
    input  logic             rst_n_i,
    // dispatch
    input  logic             disp_valid_i,
    input  alu_op_t          disp_op_i,
    input  logic [TAG_W-1:0] disp_src1_i,
    input  logic [TAG_W-1:0] disp_src2_i,
    input  logic [TAG_W-1:0] disp_dest_i,
    input  imm_t             disp_imm_i,
    // architectural state load
    input  logic             init_we_i,
    input  logic [TAG_W-1:0] init_tag_i,
    input  logic [XLEN-1:0]  init_data_i,
    // status and completion
    output logic             rs_full_o,
    output logic             cdb_valid_o,
    output logic [TAG_W-1:0] cdb_tag_o,
    output logic [XLEN-1:0]  cdb_data_o
);

    // decode to station
    logic             dec_valid;
    alu_op_t          dec_op;
    logic [TAG_W-1:0] dec_src1;
    logic             dec_src1_rdy;
    logic [TAG_W-1:0] dec_src2;
    logic             dec_src2_rdy;
    logic [TAG_W-1:0] dec_dest;
    imm_t             dec_imm;
    // station to execute
    logic             iss_valid;
    alu_op_t          iss_op;
    logic [TAG_W-1:0] iss_src1;
    logic [TAG_W-1:0] iss_src2;
    logic [TAG_W-1:0] iss_dest;
    imm_t             iss_imm;
    // operand read
    logic [TAG_W-1:0] rd_tag1;
    logic [TAG_W-1:0] rd_tag2;
    logic [XLEN-1:0]  rd_data1;
    logic [XLEN-1:0]  rd_data2;
    // execute to writeback
    logic             res_valid;
    logic [TAG_W-1:0] res_tag;
    logic [XLEN-1:0]  res_data;

    // ========================================================================
    // stages
    // ========================================================================
    dispatch_decode #(
        .PHYS_REGS (PHYS_REGS)
    ) u_dispatch_decode (
        .clock          (clock),
        .rst_n_i        (rst_n_i),
        .disp_valid_i   (disp_valid_i),
        .disp_op_i      (disp_op_i),
        .disp_src1_i    (disp_src1_i),
        .disp_src2_i    (disp_src2_i),
        .disp_dest_i    (disp_dest_i),
        .disp_imm_i     (disp_imm_i),
        .cdb_valid_i    (cdb_valid_o),
        .cdb_tag_i      (cdb_tag_o),
        .dec_valid_o    (dec_valid),
        .dec_op_o       (dec_op),
        .dec_src1_o     (dec_src1),
        .dec_src1_rdy_o (dec_src1_rdy),
        .dec_src2_o     (dec_src2),
        .dec_src2_rdy_o (dec_src2_rdy),
        .dec_dest_o     (dec_dest),
        .dec_imm_o      (dec_imm)
    );

    rs_station #(
        .PHYS_REGS (PHYS_REGS),
        .RS_DEPTH  (RS_DEPTH)
    ) u_rs_station (
        .clock          (clock),
        .rst_n_i        (rst_n_i),
        .dec_valid_i    (dec_valid),
        .dec_op_i       (dec_op),
        .dec_src1_i     (dec_src1),
        .dec_src1_rdy_i (dec_src1_rdy),
        .dec_src2_i     (dec_src2),
        .dec_src2_rdy_i (dec_src2_rdy),
        .dec_dest_i     (dec_dest),
        .dec_imm_i      (dec_imm),
        .cdb_valid_i    (cdb_valid_o),
        .cdb_tag_i      (cdb_tag_o),
        .iss_valid_o    (iss_valid),
        .iss_op_o       (iss_op),
        .iss_src1_o     (iss_src1),
        .iss_src2_o     (iss_src2),
        .iss_dest_o     (iss_dest),
        .iss_imm_o      (iss_imm),
        .rs_full_o      (rs_full_o)
    );

    alu_execute #(
        .XLEN      (XLEN),
        .PHYS_REGS (PHYS_REGS)
    ) u_alu_execute (
        .clock       (clock),
        .rst_n_i     (rst_n_i),
        .iss_valid_i (iss_valid),
        .iss_op_i    (iss_op),
        .iss_src1_i  (iss_src1),
        .iss_src2_i  (iss_src2),
        .iss_dest_i  (iss_dest),
        .iss_imm_i   (iss_imm),
        .rd_data1_i  (rd_data1),
        .rd_data2_i  (rd_data2),
        .rd_tag1_o   (rd_tag1),
        .rd_tag2_o   (rd_tag2),
        .res_valid_o (res_valid),
        .res_tag_o   (res_tag),
        .res_data_o  (res_data)
    );

    cdb_result #(
        .XLEN      (XLEN),
        .PHYS_REGS (PHYS_REGS)
    ) u_cdb_result (
        .clock       (clock),
        .rst_n_i     (rst_n_i),
        .res_valid_i (res_valid),
        .res_tag_i   (res_tag),
        .res_data_i  (res_data),
        .init_we_i   (init_we_i),
        .init_tag_i  (init_tag_i),
        .init_data_i (init_data_i),
        .rd_tag1_i   (rd_tag1),
        .rd_tag2_i   (rd_tag2),
        .rd_data1_o  (rd_data1),
        .rd_data2_o  (rd_data2),
        .cdb_valid_o (cdb_valid_o),
        .cdb_tag_o   (cdb_tag_o),
        .cdb_data_o  (cdb_data_o)
    );

endmodule

// File: test/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real PERIOD_NS    = 4.0,
    parameter int  RESET_CYCLES = 3
) (
    output logic clock_o,
    output logic rst_n_o
);

    // free running clock
    initial begin : clock_toggle
        clock_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clock_o = ~clock_o;
    end

    // reset low for a few rising edges, released on a falling edge
    initial begin : reset_seq
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock_o);
        @(negedge clock_o);
        rst_n_o = 1'b1;
    end

endmodule

// File: test/tb_ooo_core.sv
`timescale 1ns/1ps

module tb_ooo_core import ooo_pkg::*; ();

    localparam int XLEN        = 32;
    localparam int PHYS_REGS   = 64;
    localparam int RS_DEPTH    = 8;
    localparam int TAG_W       = 6;
    localparam int INIT_REGS   = 16;
    localparam int FIRST_DEST  = 16;
    localparam int RAND_INSTR  = 24;
    localparam int TOTAL_INSTR = 48;
    localparam int RESET_LIMIT = 20;
    localparam int FULL_LIMIT  = 200;
    localparam int DRAIN_LIMIT = 2000;

    logic             clock;
    logic             rst_n;
    logic             disp_valid;
    alu_op_t          disp_op;
    logic [TAG_W-1:0] disp_src1;
    logic [TAG_W-1:0] disp_src2;
    logic [TAG_W-1:0] disp_dest;
    imm_t             disp_imm;
    logic             init_we;
    logic [TAG_W-1:0] init_tag;
    logic [XLEN-1:0]  init_data;
    logic             rs_full_o;
    logic             cdb_valid_o;
    logic [TAG_W-1:0] cdb_tag_o;
    logic [XLEN-1:0]  cdb_data_o;

    // scoreboard and model state
    logic [31:0]      lfsr_q;
    logic [XLEN-1:0]  model_val [PHYS_REGS];
    int               done_cnt  [PHYS_REGS];
    bit [PHYS_REGS-1:0] dispatched;
    int               completed;
    int               mismatch_errs;
    int               other_errs;
    bit               full_seen;
    bit               timed_out;

    tb_clock_gen #(
        .PERIOD_NS    (4.0),
        .RESET_CYCLES (3)
    ) u_clock_gen (
        .clock_o (clock),
        .rst_n_o (rst_n)
    );

    ooo_core #(
        .XLEN      (XLEN),
        .PHYS_REGS (PHYS_REGS),
        .RS_DEPTH  (RS_DEPTH)
    ) u_ooo_core (
        .clock        (clock),
        .rst_n_i      (rst_n),
        .disp_valid_i (disp_valid),
        .disp_op_i    (disp_op),
        .disp_src1_i  (disp_src1),
        .disp_src2_i  (disp_src2),
        .disp_dest_i  (disp_dest),
        .disp_imm_i   (disp_imm),
        .init_we_i    (init_we),
        .init_tag_i   (init_tag),
        .init_data_i  (init_data),
        .rs_full_o    (rs_full_o),
        .cdb_valid_o  (cdb_valid_o),
        .cdb_tag_o    (cdb_tag_o),
        .cdb_data_o   (cdb_data_o)
    );

    // ========================================================================
    // random source and reference model
    // ========================================================================
    // taps x^32 + x^22 + x^2 + x + 1 with the new bit shifted in at the bottom
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit taken
    task automatic draw_bits(input int n, output logic [31:0] val);
        logic [31:0] acc;
        acc = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = lfsr_next(lfsr_q);
            acc    = {acc[30:0], lfsr_q[0]};
        end
        val = acc;
    endtask

    // expected result per opcode
    function automatic logic [XLEN-1:0] alu_model(input alu_op_t op,
                                                  input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b,
                                                  input imm_t imm);
        logic [XLEN-1:0] imm_sx;
        imm_sx = {{20{imm[11]}}, imm};
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << b[4:0];
            OP_SRL:  return a >> b[4:0];
            default: return a + imm_sx;
        endcase
    endfunction

    // ========================================================================
    // stimulus tasks
    // ========================================================================
    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (!rst_n && cycles < RESET_LIMIT) begin
            @(negedge clock);
            cycles++;
        end
        if (!rst_n) begin
            other_errs++;
            timed_out = 1'b1;
            $display("timeout: reset was never released");
        end
        @(negedge clock);
    endtask

    // architectural state through the load port
    task automatic load_registers();
        logic [31:0] rnd;
        for (int r = 0; r < INIT_REGS; r++) begin
            draw_bits(32, rnd);
            init_we   = 1'b1;
            init_tag  = TAG_W'(r);
            init_data = rnd;
            model_val[TAG_W'(r)] = rnd;
            @(negedge clock);
        end
        init_we = 1'b0;
    endtask

    // holds off while the station is full and then drives for one cycle
    task automatic dispatch_instr(input alu_op_t op, input logic [TAG_W-1:0] s1,
                                  input logic [TAG_W-1:0] s2,
                                  input logic [TAG_W-1:0] dest, input imm_t imm);
        int cycles;
        cycles     = 0;
        disp_valid = 1'b0;
        while (rs_full_o && cycles < FULL_LIMIT) begin
            @(negedge clock);
            cycles++;
        end
        if (rs_full_o) begin
            other_errs++;
            timed_out = 1'b1;
            $display("timeout: station stayed full before dispatch of tag %0d", dest);
        end else begin
            disp_valid = 1'b1;
            disp_op    = op;
            disp_src1  = s1;
            disp_src2  = s2;
            disp_dest  = dest;
            disp_imm   = imm;
            // model in program order since the sources are already modelled
            model_val[dest]  = alu_model(op, model_val[s1], model_val[s2], imm);
            dispatched[dest] = 1'b1;
            @(negedge clock);
            disp_valid = 1'b0;
        end
    endtask

    // counted wait until the cdb has returned the given number of results
    task automatic wait_completed(input int target);
        int cycles;
        cycles = 0;
        while (completed < target && cycles < DRAIN_LIMIT) begin
            @(negedge clock);
            cycles++;
        end
        if (completed < target) begin
            other_errs++;
            timed_out = 1'b1;
            $display("timeout: only %0d of %0d instructions completed", completed,
                     target);
        end
    endtask

    task automatic final_checks();
        logic [TAG_W-1:0] tg;
        for (int t = FIRST_DEST; t < PHYS_REGS; t++) begin
            tg = TAG_W'(t);
            if (done_cnt[tg] != 1) begin
                other_errs++;
                $display("tag %0d appeared on the cdb %0d times, not once", tg, done_cnt[tg]);
            end
        end
        if (!full_seen) begin
            other_errs++;
            $display("rs_full_o never went high while the chains were dispatched");
        end
        if (rs_full_o !== 1'b0) begin
            mismatch_errs++;
            $display("mismatch drain rs_full_o: expected 0 actual %0b", rs_full_o);
        end
    endtask

    // ========================================================================
    // cdb monitor
    // ========================================================================
    always @(negedge clock) begin : cdb_monitor
        if (rst_n) begin
            if (rs_full_o) begin
                full_seen = 1'b1;
            end
            if (cdb_valid_o) begin
                if (!dispatched[cdb_tag_o]) begin
                    other_errs++;
                    $display("cdb broadcast of tag %0d, which was never dispatched", cdb_tag_o);
                end else if (done_cnt[cdb_tag_o] != 0) begin
                    other_errs++;
                    $display("tag %0d broadcast a second time", cdb_tag_o);
                end else if (cdb_data_o !== model_val[cdb_tag_o]) begin
                    mismatch_errs++;
                    $display("mismatch cdb_data tag %0d: expected %08h actual %08h",
                             cdb_tag_o, model_val[cdb_tag_o], cdb_data_o);
                end
                done_cnt[cdb_tag_o]++;
                completed++;
            end
        end
    end

    // ========================================================================
    // main sequence
    // ========================================================================
    initial begin : main_flow
        logic [31:0]      rnd;
        alu_op_t          op;
        logic [TAG_W-1:0] s1;
        logic [TAG_W-1:0] s2;
        imm_t             imm;
        // every dut input idle from time zero
        disp_valid    = 1'b0;
        disp_op       = OP_ADD;
        disp_src1     = '0;
        disp_src2     = '0;
        disp_dest     = '0;
        disp_imm      = '0;
        init_we       = 1'b0;
        init_tag      = '0;
        init_data     = '0;
        lfsr_q        = 32'hf751_5604;
        dispatched    = '0;
        completed     = 0;
        mismatch_errs = 0;
        other_errs    = 0;
        full_seen     = 1'b0;
        timed_out     = 1'b0;
        for (int t = 0; t < PHYS_REGS; t++) begin
            model_val[TAG_W'(t)] = '0;
            done_cnt[TAG_W'(t)]  = 0;
        end

        wait_reset_release();
        // quiet outputs before any dispatch
        if (!timed_out) begin
            if (cdb_valid_o !== 1'b0) begin
                mismatch_errs++;
                $display("mismatch reset cdb_valid_o: expected 0 actual %0b", cdb_valid_o);
            end
            if (rs_full_o !== 1'b0) begin
                mismatch_errs++;
                $display("mismatch reset rs_full_o: expected 0 actual %0b", rs_full_o);
            end
            load_registers();
        end

        // random phase drawing sources from any earlier register
        for (int i = FIRST_DEST; i < FIRST_DEST + RAND_INSTR; i++) begin
            if (!timed_out) begin
                draw_bits(3, rnd);
                op = alu_op_t'(rnd[2:0]);
                draw_bits(6, rnd);
                s1 = TAG_W'(int'(rnd) % i);
                draw_bits(6, rnd);
                s2 = TAG_W'(int'(rnd) % i);
                draw_bits(12, rnd);
                imm = rnd[11:0];
                // addi with a negative immediate at least once
                if (i == FIRST_DEST) begin
                    op      = OP_ADDI;
                    imm[11] = 1'b1;
                end
                dispatch_instr(op, s1, s2, TAG_W'(i), imm);
            end
        end

        // the chains start on an empty station and an idle pipeline
        if (!timed_out) begin
            wait_completed(RAND_INSTR);
        end
        full_seen = 1'b0;

        // chain phase where each one waits on its predecessors
        for (int i = FIRST_DEST + RAND_INSTR; i < PHYS_REGS; i++) begin
            if (!timed_out) begin
                draw_bits(3, rnd);
                op = alu_op_t'(rnd[2:0]);
                draw_bits(12, rnd);
                imm = rnd[11:0];
                dispatch_instr(op, TAG_W'(i - 1), TAG_W'(i - 2), TAG_W'(i), imm);
                // head reaches the cdb 3 cycles after dispatch
                // so the second link is decoded during the broadcast
                if (i == FIRST_DEST + RAND_INSTR) begin
                    repeat (2) @(negedge clock);
                end
            end
        end
        disp_valid = 1'b0;

        // drain until every tag is back
        if (!timed_out) begin
            wait_completed(TOTAL_INSTR);
        end
        if (!timed_out) begin
            repeat (4) @(negedge clock);
            final_checks();
        end

        $display("errors: %0d mismatch, %0d other", mismatch_errs, other_errs);
        if (mismatch_errs == 0 && other_errs == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
design/ooo_pkg.sv
design/dispatch_decode.sv
design/rs_station.sv
design/alu_execute.sv
design/cdb_result.sv
design/ooo_core.sv
test/tb_clock_gen.sv
test/tb_ooo_core.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing
TOP       = tb_ooo_core
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
